//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define CACHE_SETS     16
`define LINE_WORDS     8
`define INDEX_BITS     4
`define WORD_BITS      3
`define TAG_BITS       9

// port widths
`define DEV_ADDR_BITS  17
`define MEM_ADDR_BITS  24
`define MEM_PAD_BITS   (`MEM_ADDR_BITS - `TAG_BITS - `INDEX_BITS - `WORD_BITS)

// device address split
`define BYTE_SEL_BIT   0
`define WORD_LSB       1
`define WORD_MSB       3
`define INDEX_LSB      4
`define INDEX_MSB      7
`define TAG_LSB        8
`define TAG_MSB        16

`endif

//--- cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    // controller states
    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,       // tag compare on latched request
        HIT_READ,     // data ram read in flight
        HIT_WRITE,    // byte merge, write_ack high
        EVICT_WAIT,   // first victim word being read
        EVICT_BURST,  // write-back to memory
        FILL_REQ,     // waiting for read burst ack
        FILL_BURST,   // eight words into victim way
        DONE          // read_ack high
    } cache_state_e;

    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`INDEX_BITS-1:0] index_t;
    typedef logic [`WORD_BITS-1:0]  word_off_t;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package mem_pkg;

    typedef logic [15:0]                mem_word_t;
    typedef logic [`MEM_ADDR_BITS-1:0]  mem_addr_t;

    // burst kinds on the memory port
    typedef enum logic [1:0] {
        BURST_NONE,
        BURST_READ,
        BURST_WRITE
    } burst_op_e;

endpackage

`default_nettype wire

//--- cache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_way (
    input  wire                  sys_clk,
    input  wire                  reset_n,
    input  wire cache_pkg::index_t    index,
    input  wire cache_pkg::word_off_t word,
    input  wire cache_pkg::tag_t      lookup_tag,
    input  wire mem_pkg::mem_word_t   wdata,
    input  wire [1:0]            byte_en,
    input  wire                  data_we,
    input  wire                  tag_we,
    input  wire                  set_dirty,
    input  wire                  clear_dirty,
    output logic                 hit,
    output logic                 dirty,
    output cache_pkg::tag_t      victim_tag,
    output mem_pkg::mem_word_t   rdata
);

    import cache_pkg::*;
    import mem_pkg::*;

    tag_t                              tag_mem [0:`CACHE_SETS-1];
    logic [`CACHE_SETS-1:0]            valid_bits;
    logic [`CACHE_SETS-1:0]            dirty_bits;
    mem_word_t                         data_mem [0:`CACHE_SETS*`LINE_WORDS-1];
    logic [`INDEX_BITS+`WORD_BITS-1:0] ram_addr;

    assign ram_addr = {index, word};  // set, then word in line

    // line state bits
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (tag_we) begin
                valid_bits[index] <= 1'b1;  // line filled
            end
            if (set_dirty) begin
                dirty_bits[index] <= 1'b1;
            end else if (clear_dirty) begin
                dirty_bits[index] <= 1'b0;  // written back
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (tag_we) begin
            tag_mem[index] <= lookup_tag;
        end
    end

    // data ram, byte write and registered read
    always_ff @(posedge sys_clk) begin
        if (data_we && byte_en[0]) begin
            data_mem[ram_addr][7:0] <= wdata[7:0];
        end
        if (data_we && byte_en[1]) begin
            data_mem[ram_addr][15:8] <= wdata[15:8];
        end
        rdata <= data_mem[ram_addr];  // old data on a write cycle
    end

    assign hit        = valid_bits[index] && (tag_mem[index] == lookup_tag);
    assign dirty      = dirty_bits[index];
    assign victim_tag = tag_mem[index];  // for write-back address

endmodule

`default_nettype wire

//--- cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_controller (
    input  wire                       sys_clk,
    input  wire                       reset_n,
    // device port
    input  wire [`DEV_ADDR_BITS-1:0]  address,
    input  wire [7:0]                 data_write,
    input  wire                       read_req,
    input  wire                       write_req,
    output logic [7:0]                data_read,
    output logic                      read_ack,
    output logic                      write_ack,
    // way slices
    input  wire                       hit0,
    input  wire                       hit1,
    input  wire                       dirty0,
    input  wire                       dirty1,
    input  wire cache_pkg::tag_t      victim_tag0,
    input  wire cache_pkg::tag_t      victim_tag1,
    input  wire mem_pkg::mem_word_t   rdata0,
    input  wire mem_pkg::mem_word_t   rdata1,
    output cache_pkg::index_t         index,
    output cache_pkg::word_off_t      word,
    output cache_pkg::tag_t           lookup_tag,
    output mem_pkg::mem_word_t        wdata,
    output logic [1:0]                byte_en,
    output logic                      data_we0,
    output logic                      data_we1,
    output logic                      tag_we0,
    output logic                      tag_we1,
    output logic                      set_dirty0,
    output logic                      set_dirty1,
    output logic                      clear_dirty0,
    output logic                      clear_dirty1,
    // memory port
    input  wire mem_pkg::mem_word_t   sdram_data_read,
    input  wire                       sdram_read_ack,
    input  wire                       sdram_write_ack,
    output mem_pkg::mem_addr_t        sdram_address,
    output mem_pkg::mem_word_t        sdram_data_write,
    output logic                      sdram_read_req,
    output logic                      sdram_write_req
);

    import cache_pkg::*;
    import mem_pkg::*;

    localparam word_off_t LAST_WORD = word_off_t'(`LINE_WORDS - 1);

    cache_state_e           state;
    logic                   req_write;   // latched request kind
    tag_t                   req_tag;
    index_t                 req_index;
    word_off_t              req_word;
    logic                   req_byte;    // 1 = high byte
    logic [7:0]             req_data;
    logic                   way_sel;     // hit way or victim way
    word_off_t              beat;        // burst word counter
    logic [`CACHE_SETS-1:0] lru;         // per set, least recently used way
    logic                   victim;
    logic                   victim_dirty;
    burst_op_e              miss_op;
    mem_word_t              sel_word;
    mem_addr_t              fill_addr;
    mem_addr_t              evict_addr;
    logic                   fill_we;
    logic                   wb_last;

    // clean way first, else the lru way
    assign victim       = (dirty0 ^ dirty1) ? dirty0 : lru[req_index];
    assign victim_dirty = victim ? dirty1 : dirty0;

    always_comb begin
        if (hit0 || hit1) begin
            miss_op = BURST_NONE;
        end else if (victim_dirty) begin
            miss_op = BURST_WRITE;  // write-back first
        end else begin
            miss_op = BURST_READ;
        end
    end

    assign sel_word   = way_sel ? rdata1 : rdata0;
    assign fill_addr  = {{`MEM_PAD_BITS{1'b0}}, req_tag, req_index, {`WORD_BITS{1'b0}}};
    assign evict_addr = {{`MEM_PAD_BITS{1'b0}}, (way_sel ? victim_tag1 : victim_tag0),
                         req_index, {`WORD_BITS{1'b0}}};

    // control state
    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= IDLE;
            read_ack        <= 1'b0;
            write_ack       <= 1'b0;
            sdram_read_req  <= 1'b0;
            sdram_write_req <= 1'b0;
            req_write       <= 1'b0;
            way_sel         <= 1'b0;
            beat            <= '0;
            lru             <= '0;
        end else begin
            read_ack  <= 1'b0;  // acks are single pulses
            write_ack <= 1'b0;
            case (state)
                IDLE: begin
                    if (read_req || write_req) begin
                        req_write <= write_req;
                        state     <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    beat <= '0;
                    case (miss_op)
                        BURST_NONE: begin
                            way_sel        <= hit1;
                            lru[req_index] <= hit0;  // other way is now lru
                            if (req_write) begin
                                write_ack <= 1'b1;
                                state     <= HIT_WRITE;
                            end else begin
                                state <= HIT_READ;
                            end
                        end
                        BURST_WRITE: begin
                            way_sel <= victim;
                            state   <= EVICT_WAIT;
                        end
                        default: begin
                            way_sel        <= victim;
                            sdram_read_req <= 1'b1;
                            state          <= FILL_REQ;
                        end
                    endcase
                end
                HIT_READ: begin
                    read_ack <= 1'b1;
                    state    <= DONE;
                end
                HIT_WRITE: begin
                    state <= IDLE;
                end
                DONE: begin
                    state <= IDLE;
                end
                EVICT_WAIT: begin
                    sdram_write_req <= 1'b1;  // word 0 is on rdata now
                    state           <= EVICT_BURST;
                end
                EVICT_BURST: begin
                    if (sdram_write_ack) begin
                        if (beat == LAST_WORD) begin
                            sdram_write_req <= 1'b0;
                            sdram_read_req  <= 1'b1;
                            state           <= FILL_REQ;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                FILL_REQ: begin
                    if (sdram_read_ack) begin
                        sdram_read_req <= 1'b0;
                        beat           <= '0;
                        state          <= FILL_BURST;
                    end
                end
                FILL_BURST: begin
                    beat <= beat + 1'b1;
                    if (beat == LAST_WORD) begin
                        state <= LOOKUP;  // completes as a hit
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and memory payload
    always_ff @(posedge sys_clk) begin
        case (state)
            IDLE: begin
                if (read_req || write_req) begin
                    req_tag   <= address[`TAG_MSB:`TAG_LSB];
                    req_index <= address[`INDEX_MSB:`INDEX_LSB];
                    req_word  <= address[`WORD_MSB:`WORD_LSB];
                    req_byte  <= address[`BYTE_SEL_BIT];
                    req_data  <= data_write;
                end
            end
            LOOKUP: begin
                if (miss_op == BURST_READ) begin
                    sdram_address <= fill_addr;
                end
            end
            HIT_READ: begin
                data_read <= req_byte ? sel_word[15:8] : sel_word[7:0];
            end
            EVICT_WAIT: begin
                sdram_address <= evict_addr;
            end
            EVICT_BURST: begin
                if (sdram_write_ack) begin
                    if (beat == LAST_WORD) begin
                        sdram_address <= fill_addr;
                    end else begin
                        sdram_address <= sdram_address + 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // ram word, one ahead on a write-back ack so the next word is ready
    always_comb begin
        case (state)
            EVICT_WAIT:  word = beat;
            EVICT_BURST: word = sdram_write_ack ? word_off_t'(beat + 1'b1) : beat;
            FILL_BURST:  word = beat;
            default:     word = req_word;
        endcase
    end

    assign index      = req_index;
    assign lookup_tag = req_tag;
    assign fill_we    = (state == FILL_BURST);
    assign wdata      = fill_we ? sdram_data_read : {req_data, req_data};
    assign byte_en    = fill_we ? 2'b11 : (req_byte ? 2'b10 : 2'b01);
    assign wb_last    = (state == EVICT_BURST) && sdram_write_ack && (beat == LAST_WORD);

    assign data_we0     = (fill_we || state == HIT_WRITE) && !way_sel;
    assign data_we1     = (fill_we || state == HIT_WRITE) && way_sel;
    assign tag_we0      = fill_we && (beat == LAST_WORD) && !way_sel;
    assign tag_we1      = fill_we && (beat == LAST_WORD) && way_sel;
    assign set_dirty0   = (state == HIT_WRITE) && !way_sel;
    assign set_dirty1   = (state == HIT_WRITE) && way_sel;
    assign clear_dirty0 = wb_last && !way_sel;
    assign clear_dirty1 = wb_last && way_sel;

    assign sdram_data_write = sel_word;  // victim word during write-back

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top (
    input  wire                       sys_clk,
    input  wire                       reset_n,
    // device port
    input  wire [`DEV_ADDR_BITS-1:0]  address,
    input  wire [7:0]                 data_write,
    input  wire                       read_req,
    input  wire                       write_req,
    output logic [7:0]                data_read,
    output logic                      read_ack,
    output logic                      write_ack,
    // memory port
    output mem_pkg::mem_addr_t        sdram_address,
    output mem_pkg::mem_word_t        sdram_data_write,
    input  wire mem_pkg::mem_word_t   sdram_data_read,
    output logic                      sdram_read_req,
    output logic                      sdram_write_req,
    input  wire                       sdram_read_ack,
    input  wire                       sdram_write_ack
);

    import cache_pkg::*;
    import mem_pkg::*;

    // shared to both ways
    index_t    index;
    word_off_t word;
    tag_t      lookup_tag;
    mem_word_t wdata;
    logic [1:0] byte_en;

    // per way
    logic      hit0, hit1;
    logic      dirty0, dirty1;
    tag_t      victim_tag0, victim_tag1;
    mem_word_t rdata0, rdata1;
    logic      data_we0, data_we1;
    logic      tag_we0, tag_we1;
    logic      set_dirty0, set_dirty1;
    logic      clear_dirty0, clear_dirty1;

    cache_way way0 (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .index(index), .word(word), .lookup_tag(lookup_tag),
        .wdata(wdata), .byte_en(byte_en),
        .data_we(data_we0), .tag_we(tag_we0),
        .set_dirty(set_dirty0), .clear_dirty(clear_dirty0),
        .hit(hit0), .dirty(dirty0), .victim_tag(victim_tag0), .rdata(rdata0)
    );

    cache_way way1 (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .index(index), .word(word), .lookup_tag(lookup_tag),
        .wdata(wdata), .byte_en(byte_en),
        .data_we(data_we1), .tag_we(tag_we1),
        .set_dirty(set_dirty1), .clear_dirty(clear_dirty1),
        .hit(hit1), .dirty(dirty1), .victim_tag(victim_tag1), .rdata(rdata1)
    );

    cache_controller ctrl (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .address(address), .data_write(data_write),
        .read_req(read_req), .write_req(write_req),
        .data_read(data_read), .read_ack(read_ack), .write_ack(write_ack),
        .hit0(hit0), .hit1(hit1), .dirty0(dirty0), .dirty1(dirty1),
        .victim_tag0(victim_tag0), .victim_tag1(victim_tag1),
        .rdata0(rdata0), .rdata1(rdata1),
        .index(index), .word(word), .lookup_tag(lookup_tag),
        .wdata(wdata), .byte_en(byte_en),
        .data_we0(data_we0), .data_we1(data_we1),
        .tag_we0(tag_we0), .tag_we1(tag_we1),
        .set_dirty0(set_dirty0), .set_dirty1(set_dirty1),
        .clear_dirty0(clear_dirty0), .clear_dirty1(clear_dirty1),
        .sdram_data_read(sdram_data_read),
        .sdram_read_ack(sdram_read_ack), .sdram_write_ack(sdram_write_ack),
        .sdram_address(sdram_address), .sdram_data_write(sdram_data_write),
        .sdram_read_req(sdram_read_req), .sdram_write_req(sdram_write_req)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_mem_model (
    input  wire                     sys_clk,
    input  wire                     reset_n,
    input  wire mem_pkg::mem_addr_t sdram_address,
    input  wire mem_pkg::mem_word_t sdram_data_write,
    input  wire                     sdram_read_req,
    input  wire                     sdram_write_req,
    output mem_pkg::mem_word_t      sdram_data_read,
    output logic                    sdram_read_ack,
    output logic                    sdram_write_ack
);

    import mem_pkg::*;

    localparam int MODEL_WORDS = 1 << (`DEV_ADDR_BITS - 1);  // upper address bits are zero

    mem_word_t mem [0:MODEL_WORDS-1];
    burst_op_e op;
    mem_addr_t base;
    int        seed = 32'hc0ea31d9;

    // 0 to 3 idle cycles before an ack
    task automatic wait_random();
        int n;
        n = $random(seed) & 32'h3;
        repeat (n) @(negedge sys_clk);
    endtask

    initial begin
        for (int a = 0; a < MODEL_WORDS; a++) begin
            mem[a] = mem_word_t'(a * 3 + 1);
        end
        sdram_data_read = '0;
        sdram_read_ack  = 1'b0;
        sdram_write_ack = 1'b0;
        op              = BURST_NONE;
        forever begin
            @(negedge sys_clk);
            if (!reset_n) begin
                op = BURST_NONE;
            end else if (sdram_write_req) begin
                op = BURST_WRITE;
            end else if (sdram_read_req) begin
                op = BURST_READ;
            end else begin
                op = BURST_NONE;
            end
            case (op)
                BURST_WRITE: begin
                    for (int i = 0; i < `LINE_WORDS; i++) begin
                        wait_random();
                        mem[sdram_address[`DEV_ADDR_BITS-2:0]] = sdram_data_write;
                        sdram_write_ack = 1'b1;  // word taken at next posedge
                        @(negedge sys_clk);
                        sdram_write_ack = 1'b0;
                    end
                end
                BURST_READ: begin
                    wait_random();
                    base           = sdram_address;
                    sdram_read_ack = 1'b1;
                    @(negedge sys_clk);
                    sdram_read_ack = 1'b0;
                    for (int i = 0; i < `LINE_WORDS; i++) begin
                        sdram_data_read = mem[base[`DEV_ADDR_BITS-2:0] + i];
                        @(negedge sys_clk);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cache_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_props (
    input wire                          sys_clk,
    input wire                          reset_n,
    input wire [`DEV_ADDR_BITS-1:0]     address,
    input wire [7:0]                    data_write,
    input wire                          read_req,
    input wire                          write_req,
    input wire [7:0]                    data_read,
    input wire                          read_ack,
    input wire                          write_ack,
    input wire mem_pkg::mem_addr_t      sdram_address,
    input wire mem_pkg::mem_word_t      sdram_data_write,
    input wire                          sdram_read_req,
    input wire                          sdram_write_req,
    input wire                          sdram_read_ack,
    input wire                          sdram_write_ack,
    input wire cache_pkg::cache_state_e state
);

    import cache_pkg::*;
    import mem_pkg::*;

    logic [7:0]                shadow [0:(1 << `DEV_ADDR_BITS)-1];
    logic [15:0]               init_word;
    logic [`DEV_ADDR_BITS-1:0] req_addr;
    logic [7:0]                req_data;
    logic [`DEV_ADDR_BITS-1:0] rd_addr;
    logic                      rd_valid;
    logic [3:0]                wr_cnt;
    mem_addr_t                 wr_prev;
    logic [`DEV_ADDR_BITS-1:0] wb_lo;
    int                        fail_count = 0;

    initial begin
        for (int a = 0; a < (1 << `DEV_ADDR_BITS); a++) begin
            init_word = 16'(a / 2 * 3 + 1);  // same rule as the memory model
            shadow[a] = a[0] ? init_word[15:8] : init_word[7:0];
        end
    end

    assign wb_lo = {sdram_address[`DEV_ADDR_BITS-2:0], 1'b0};

    always @(posedge sys_clk) begin
        if (state == IDLE && (read_req || write_req)) begin
            req_addr <= address;
            req_data <= data_write;
        end
        if (reset_n && write_ack) begin
            shadow[req_addr] <= req_data;
        end
    end

    always @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
            wr_cnt   <= '0;
        end else begin
            if (read_ack) begin
                rd_valid <= 1'b1;
                rd_addr  <= req_addr;
            end else if (write_ack) begin
                rd_valid <= 1'b0;  // a write breaks the back-to-back read
            end
            if (!sdram_write_req) begin
                wr_cnt <= '0;
            end else if (sdram_write_ack) begin
                wr_cnt  <= wr_cnt + 1'b1;
                wr_prev <= sdram_address;
            end
        end
    end

    a_read_data: assert property (@(posedge sys_clk) disable iff (!reset_n)
        read_ack |-> data_read == shadow[req_addr])
        else begin
            fail_count++;
            $error("Mismatch at %0t: read of %h returned %h", $time, req_addr, data_read);
        end

    a_wb_data: assert property (@(posedge sys_clk) disable iff (!reset_n)
        sdram_write_ack |-> sdram_data_write == {shadow[wb_lo + 1], shadow[wb_lo]})
        else begin
            fail_count++;
            $error("Mismatch at %0t: write-back word %h at %h", $time, sdram_data_write,
                   sdram_address);
        end

    a_wr_beat: assert property (@(posedge sys_clk) disable iff (!reset_n)
        sdram_write_ack |-> sdram_write_req && sdram_address[2:0] == wr_cnt[2:0]
                            && (wr_cnt == 0 || sdram_address == wr_prev + 1))
        else begin
            fail_count++;
            $error("Mismatch at %0t: write burst address %h", $time, sdram_address);
        end

    a_wr_count: assert property (@(posedge sys_clk) disable iff (!reset_n)
        $fell(sdram_write_req) |-> wr_cnt == 8)
        else begin
            fail_count++;
            $error("write burst at %0t did not carry eight words", $time);
        end

    a_rd_burst: assert property (@(posedge sys_clk) disable iff (!reset_n)
        sdram_read_ack |-> sdram_read_req && sdram_address[2:0] == 3'd0
                           ##1 (state == FILL_BURST) [*8] ##1 state == LOOKUP)
        else begin
            fail_count++;
            $error("read burst at %0t is unaligned or not eight words long", $time);
        end

    a_burst_excl: assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(sdram_read_req && sdram_write_req))
        else begin
            fail_count++;
            $error("read and write burst requests both high at %0t", $time);
        end

    a_ack_rules: assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(read_ack && write_ack) && (!read_ack || read_req) && (!write_ack || write_req))
        else begin
            fail_count++;
            $error("acknowledge at %0t without its request or with the other ack", $time);
        end

    a_ack_pulse: assert property (@(posedge sys_clk) disable iff (!reset_n)
        (read_ack || write_ack) |=> !read_ack && !write_ack)
        else begin
            fail_count++;
            $error("acknowledge at %0t lasted more than one cycle", $time);
        end

    a_hit_time: assert property (@(posedge sys_clk) disable iff (!reset_n)
        state == IDLE && read_req && rd_valid && address == rd_addr |-> ##3 read_ack)
        else begin
            fail_count++;
            $error("repeated read at %0t was not acknowledged after 3 cycles", $time);
        end

endmodule

`default_nettype wire

//--- tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache;

    import mem_pkg::*;

    localparam int ACCESS_COUNT = 300;
    localparam int CYCLE_LIMIT  = 20000;  // 300 accesses of up to ~55 cycles, plus margin

    logic                      sys_clk = 1'b0;
    logic                      reset_n;
    logic [`DEV_ADDR_BITS-1:0] address;
    logic [7:0]                data_write;
    logic                      read_req;
    logic                      write_req;
    logic [7:0]                data_read;
    logic                      read_ack;
    logic                      write_ack;
    mem_addr_t                 sdram_address;
    mem_word_t                 sdram_data_write;
    mem_word_t                 sdram_data_read;
    logic                      sdram_read_req;
    logic                      sdram_write_req;
    logic                      sdram_read_ack;
    logic                      sdram_write_ack;
    logic [`DEV_ADDR_BITS-1:0] last_rd_addr;
    int                        seed = 32'hc0ea31d9;
    int                        accesses = 0;
    int                        cycles = 0;

    cache_top uut (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .address(address), .data_write(data_write),
        .read_req(read_req), .write_req(write_req),
        .data_read(data_read), .read_ack(read_ack), .write_ack(write_ack),
        .sdram_address(sdram_address), .sdram_data_write(sdram_data_write),
        .sdram_data_read(sdram_data_read),
        .sdram_read_req(sdram_read_req), .sdram_write_req(sdram_write_req),
        .sdram_read_ack(sdram_read_ack), .sdram_write_ack(sdram_write_ack)
    );

    tb_mem_model mem_model (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .sdram_address(sdram_address), .sdram_data_write(sdram_data_write),
        .sdram_read_req(sdram_read_req), .sdram_write_req(sdram_write_req),
        .sdram_data_read(sdram_data_read),
        .sdram_read_ack(sdram_read_ack), .sdram_write_ack(sdram_write_ack)
    );

    bind cache_top cache_props props (
        .sys_clk(sys_clk), .reset_n(reset_n),
        .address(address), .data_write(data_write),
        .read_req(read_req), .write_req(write_req),
        .data_read(data_read), .read_ack(read_ack), .write_ack(write_ack),
        .sdram_address(sdram_address), .sdram_data_write(sdram_data_write),
        .sdram_read_req(sdram_read_req), .sdram_write_req(sdram_write_req),
        .sdram_read_ack(sdram_read_ack), .sdram_write_ack(sdram_write_ack),
        .state(ctrl.state)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit after %0d cycles", cycles);
        end
    end

    initial begin
        wait (uut.props.fail_count != 0);
        $display("Simulation failed");
        $fatal(1, "assertion error reported at %0t", $time);
    end

    // four tags over four sets, so lines collide often
    function automatic logic [`DEV_ADDR_BITS-1:0] random_addr();
        int r;
        r = $random(seed);
        return {r[9:8], 7'h2b, 2'b00, r[3:2], r[7:4]};
    endfunction

    task automatic read_byte(input logic [`DEV_ADDR_BITS-1:0] addr);
        @(negedge sys_clk);
        address  = addr;
        read_req = 1'b1;
        do begin
            @(negedge sys_clk);
        end while (!read_ack);
        @(negedge sys_clk);
        read_req     = 1'b0;
        last_rd_addr = addr;
        accesses++;
    endtask

    task automatic write_byte(input logic [`DEV_ADDR_BITS-1:0] addr, input logic [7:0] data);
        @(negedge sys_clk);
        address    = addr;
        data_write = data;
        write_req  = 1'b1;
        do begin
            @(negedge sys_clk);
        end while (!write_ack);
        @(negedge sys_clk);
        write_req = 1'b0;
        accesses++;
    endtask

    initial begin
        int r;
        reset_n    = 1'b0;
        address    = '0;
        data_write = '0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        repeat (5) @(posedge sys_clk);
        @(negedge sys_clk);
        reset_n = 1'b1;

        read_byte({9'h012, 4'h3, 4'h7});   // cold miss
        read_byte({9'h012, 4'h3, 4'h7});   // hit straight after
        write_byte({9'h040, 4'h9, 4'h6}, 8'h5a);
        read_byte({9'h040, 4'h9, 4'h6});
        write_byte({9'h011, 4'h5, 4'h5}, 8'ha1);  // three tags into set 5
        write_byte({9'h022, 4'h5, 4'h5}, 8'hb2);
        write_byte({9'h033, 4'h5, 4'h5}, 8'hc3);  // evicts a dirty line
        read_byte({9'h011, 4'h5, 4'h5});
        read_byte({9'h022, 4'h5, 4'h5});
        read_byte({9'h033, 4'h5, 4'h5});

        while (accesses < ACCESS_COUNT) begin
            r = $random(seed);
            case (r[1:0])
                2'd0, 2'd1: read_byte(random_addr());
                2'd2:       write_byte(random_addr(), r[15:8]);
                default:    read_byte(last_rd_addr);
            endcase
        end

        repeat (4) @(negedge sys_clk);
        if (uut.props.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "%0d assertion errors", uut.props.fail_count);
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
cache_pkg.sv
mem_pkg.sv
cache_way.sv
cache_controller.sv
cache_top.sv
tb_mem_model.sv
cache_props.sv
tb_cache.sv
